/* hdl/accel_config.svh */
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

// bits per memory page
`define ACCEL_PAGE_W 64

// 8-bit pixels or weights in one page
`define ACCEL_PIX_PER_PAGE 8

// pages per image, same count for one weight set
`define ACCEL_IMG_PAGES 4

// page buffers hold exactly one image or one weight set
`define ACCEL_BUF_DEPTH `ACCEL_IMG_PAGES

// page address into external memory
`define ACCEL_ADDR_W 28

// 32-bit words in a program page
`define ACCEL_INSTR_PER_PAGE 2

`endif

/* hdl/accel_pkg.sv */
package accel_pkg;

`include "accel_config.svh"

    // raw memory page
    typedef logic [`ACCEL_PAGE_W-1:0] mem_page_t;

    // unsigned pixels, element 0 in the low byte
    typedef logic [`ACCEL_PIX_PER_PAGE-1:0][7:0] pixel_page_t;

    typedef logic signed [7:0] weight_t;

    // signed weights, same byte order as pixels
    typedef weight_t [`ACCEL_PIX_PER_PAGE-1:0] weight_page_t;

    typedef logic [31:0] instr_t;

    // one access toward memory, strobes are single cycle
    typedef struct packed {
        logic                     rd_req;
        logic                     wr_req;
        logic [`ACCEL_ADDR_W-1:0] addr;
    } mem_req_t;

    // decoder register selects
    typedef enum logic [1:0] {
        REG_IMG_ADDR = 2'd0,
        REG_IMG_CNT  = 2'd1,
        REG_RES_ADDR = 2'd2
    } reg_sel_t;

    // register write from the decoder
    typedef struct packed {
        logic                     wr_en;
        reg_sel_t                 sel;
        logic [`ACCEL_ADDR_W-1:0] data;
    } reg_cmd_t;

    // wide enough for 32 products of u8 by s8
    typedef logic signed [23:0] acc_t;

endpackage

/* hdl/page_buffer.sv */
`timescale 1ns/1ps

module page_buffer #(
    parameter type page_t = logic [63:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  shift,
    input  page_t d,
    output page_t q [DEPTH]
);

    // entry 0 holds the newest page
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                q[i] <= '0;
            end
        end else if (shift) begin
            q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                q[i] <= q[i-1];
            end
        end
    end

    // memory must return clean data with every valid strobe
    a_no_x_on_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        shift |-> !$isunknown(d)
    ) else $error("page_buffer: unknown bits shifted in");

endmodule

/* hdl/mac_engine.sv */
`timescale 1ns/1ps
`include "accel_config.svh"

module mac_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mac_start,
    input  accel_pkg::pixel_page_t  pixels  [`ACCEL_IMG_PAGES],
    input  accel_pkg::weight_page_t weights [`ACCEL_IMG_PAGES],
    input  logic                   res_ack,
    output logic                   res_vld,
    output accel_pkg::acc_t        res_data
);
    import accel_pkg::*;

    localparam int PG_W = $clog2(`ACCEL_IMG_PAGES);
    localparam logic [PG_W-1:0] LAST_PAGE = PG_W'(`ACCEL_IMG_PAGES - 1);

    logic            busy;
    logic [PG_W-1:0] page_idx;
    logic [PG_W-1:0] sel;
    acc_t            page_sum;
    acc_t            acc;

    // eight products of unsigned pixel and signed weight
    function automatic acc_t dot_page(pixel_page_t p, weight_page_t w);
        acc_t s;
        acc_t px;
        acc_t wt;
        s = '0;
        for (int i = 0; i < `ACCEL_PIX_PER_PAGE; i++) begin
            px = p[i];
            wt = w[i];
            s  = s + px * wt;
        end
        return s;
    endfunction

    // page 0 is summed in the start cycle itself
    assign sel      = busy ? page_idx : '0;
    assign page_sum = dot_page(pixels[sel], weights[sel]);
    assign res_data = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            page_idx <= '0;
            res_vld  <= 1'b0;
        end else begin
            if (mac_start) begin
                busy     <= 1'b1;
                page_idx <= PG_W'(1);
            end else if (busy) begin
                page_idx <= page_idx + 1'b1;
                if (page_idx == LAST_PAGE) begin
                    busy    <= 1'b0;
                    res_vld <= 1'b1;
                end
            end
            if (res_ack) begin
                res_vld <= 1'b0;
            end
        end
    end

    // result stays put after the walk until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (mac_start) begin
            acc <= page_sum;
        end else if (busy) begin
            acc <= acc + page_sum;
        end
    end

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        mac_start |-> !busy && !res_vld
    ) else $error("mac_engine: start while busy or result pending");

    a_ack_with_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_ack |-> res_vld
    ) else $error("mac_engine: ack without a result");

    a_fixed_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        mac_start |-> ##(`ACCEL_IMG_PAGES) $rose(res_vld)
    ) else $error("mac_engine: result latency off");

endmodule

/* hdl/ctrl_unit.sv */
`timescale 1ns/1ps
`include "accel_config.svh"

module ctrl_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                buffer_addr_valid,
    input  logic                data_valid,
    input  logic                write_done,
    input  accel_pkg::reg_cmd_t cmd,
    input  logic                begin_wgt_load,
    input  logic                begin_proc,
    input  logic                res_vld,
    output accel_pkg::mem_req_t mem_req,
    output logic                img_shift,
    output logic                wgt_shift,
    output logic                mac_start,
    output logic                res_ack,
    output logic                instr_vld,
    output logic                inc_pc
);
    import accel_pkg::*;

    localparam int PG_W = $clog2(`ACCEL_IMG_PAGES);
    localparam int AW   = `ACCEL_ADDR_W;
    localparam logic [PG_W-1:0] LAST_PAGE = PG_W'(`ACCEL_IMG_PAGES - 1);

    typedef enum logic [3:0] {
        ST_WAIT_BUF,
        ST_FETCH,
        ST_WAIT_PROG,
        ST_EXEC,
        ST_WGT_LOAD,
        ST_IMG_LOAD,
        ST_COMPUTE,
        ST_WRITE,
        ST_WAIT_WR
    } state_t;

    state_t state;

    // programmable through cmd
    logic [AW-1:0] img_addr;
    logic [AW-1:0] img_cnt;
    logic [AW-1:0] res_addr;

    logic [AW-1:0]   wgt_addr;
    logic [AW-1:0]   img_idx;
    logic [PG_W-1:0] page_cnt;
    logic            rd_pend;

    logic start_wgt;
    logic start_proc;
    logic img_page_in;
    logic last_page;
    logic wr_fin;

    assign start_wgt   = state == ST_EXEC && begin_wgt_load;
    assign start_proc  = state == ST_EXEC && begin_proc && !begin_wgt_load;
    assign img_page_in = data_valid && state == ST_IMG_LOAD;
    assign last_page   = page_cnt == LAST_PAGE;
    assign wr_fin      = state == ST_WAIT_WR && write_done;

    // program page lands in the image buffer too
    assign img_shift = data_valid && (state == ST_WAIT_PROG || state == ST_IMG_LOAD);
    assign wgt_shift = data_valid && state == ST_WGT_LOAD;
    assign res_ack   = state == ST_WRITE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_WAIT_BUF;
            rd_pend   <= 1'b0;
            mac_start <= 1'b0;
            instr_vld <= 1'b0;
            inc_pc    <= 1'b0;
        end else begin
            rd_pend   <= 1'b0;
            mac_start <= 1'b0;
            instr_vld <= 1'b0;
            inc_pc    <= 1'b0;
            case (state)
                ST_WAIT_BUF: begin
                    if (buffer_addr_valid) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    state <= ST_WAIT_PROG;
                end
                ST_WAIT_PROG: begin
                    if (data_valid) begin
                        state     <= ST_EXEC;
                        instr_vld <= 1'b1;
                    end
                end
                ST_EXEC: begin
                    if (start_wgt) begin
                        state   <= ST_WGT_LOAD;
                        rd_pend <= 1'b1;
                    end else if (start_proc) begin
                        // nothing to process, step on
                        if (img_cnt == '0) begin
                            inc_pc <= 1'b1;
                        end else begin
                            state   <= ST_IMG_LOAD;
                            rd_pend <= 1'b1;
                        end
                    end
                end
                ST_WGT_LOAD: begin
                    if (data_valid) begin
                        if (last_page) begin
                            state  <= ST_EXEC;
                            inc_pc <= 1'b1;
                        end else begin
                            rd_pend <= 1'b1;
                        end
                    end
                end
                ST_IMG_LOAD: begin
                    if (data_valid) begin
                        if (last_page) begin
                            state     <= ST_COMPUTE;
                            mac_start <= 1'b1;
                        end else begin
                            rd_pend <= 1'b1;
                        end
                    end
                end
                ST_COMPUTE: begin
                    if (res_vld) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    state <= ST_WAIT_WR;
                end
                ST_WAIT_WR: begin
                    if (write_done) begin
                        // img_cnt counts down on this same edge
                        if (img_cnt == AW'(1)) begin
                            state  <= ST_EXEC;
                            inc_pc <= 1'b1;
                        end else begin
                            state   <= ST_IMG_LOAD;
                            rd_pend <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_WAIT_BUF;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_addr <= '0;
            img_cnt  <= '0;
            res_addr <= '0;
        end else if (cmd.wr_en) begin
            case (cmd.sel)
                REG_IMG_ADDR: img_addr <= cmd.data;
                REG_IMG_CNT:  img_cnt  <= cmd.data;
                REG_RES_ADDR: res_addr <= cmd.data;
                default:      res_addr <= res_addr;
            endcase
        end else begin
            // image address walks on through all images
            if (img_page_in) begin
                img_addr <= img_addr + 1'b1;
            end
            if (wr_fin) begin
                img_cnt <= img_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wgt_addr <= '0;
            page_cnt <= '0;
            img_idx  <= '0;
        end else begin
            if (start_wgt) begin
                wgt_addr <= cmd.data;
            end else if (wgt_shift) begin
                wgt_addr <= wgt_addr + 1'b1;
            end
            if (start_wgt || start_proc || wr_fin) begin
                page_cnt <= '0;
            end else if (wgt_shift || img_page_in) begin
                page_cnt <= page_cnt + 1'b1;
            end
            if (start_proc) begin
                img_idx <= '0;
            end else if (wr_fin) begin
                img_idx <= img_idx + 1'b1;
            end
        end
    end

    always_comb begin
        mem_req        = '0;
        mem_req.rd_req = state == ST_FETCH || rd_pend;
        mem_req.wr_req = state == ST_WRITE;
        case (state)
            ST_WGT_LOAD: mem_req.addr = wgt_addr;
            ST_IMG_LOAD: mem_req.addr = img_addr;
            ST_WRITE:    mem_req.addr = res_addr + img_idx;
            // program page sits at page 0
            default:     mem_req.addr = '0;
        endcase
    end

    a_begin_in_exec: assert property (
        @(posedge clk) disable iff (!rst_n)
        (begin_wgt_load || begin_proc) |-> state == ST_EXEC
    ) else $error("ctrl_unit: begin command while busy, ignored");

endmodule

/* hdl/accel_core.sv */
`timescale 1ns/1ps
`include "accel_config.svh"

module accel_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output accel_pkg::mem_req_t  mem_req,
    input  logic                 data_valid,
    input  accel_pkg::mem_page_t read_data,
    output accel_pkg::mem_page_t write_data,
    input  logic                 write_done,
    input  logic                 buffer_addr_valid,
    input  accel_pkg::reg_cmd_t  cmd,
    input  logic                 begin_wgt_load,
    input  logic                 begin_proc,
    output accel_pkg::instr_t    instructions [`ACCEL_INSTR_PER_PAGE],
    output logic                 instr_vld,
    output logic                 inc_pc
);
    import accel_pkg::*;

    localparam int INSTR_W = $bits(instr_t);
    localparam int ACC_W   = $bits(acc_t);

    logic         img_shift;
    logic         wgt_shift;
    logic         mac_start;
    logic         res_ack;
    logic         res_vld;
    acc_t         res_data;
    mem_page_t    prog_page;
    pixel_page_t  img_q [`ACCEL_BUF_DEPTH];
    weight_page_t wgt_q [`ACCEL_BUF_DEPTH];

    ctrl_unit ctrl_unit_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .buffer_addr_valid (buffer_addr_valid),
        .data_valid        (data_valid),
        .write_done        (write_done),
        .cmd               (cmd),
        .begin_wgt_load    (begin_wgt_load),
        .begin_proc        (begin_proc),
        .res_vld           (res_vld),
        .mem_req           (mem_req),
        .img_shift         (img_shift),
        .wgt_shift         (wgt_shift),
        .mac_start         (mac_start),
        .res_ack           (res_ack),
        .instr_vld         (instr_vld),
        .inc_pc            (inc_pc)
    );

    page_buffer #(
        .page_t (pixel_page_t),
        .DEPTH  (`ACCEL_BUF_DEPTH)
    ) img_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .shift (img_shift),
        .d     (pixel_page_t'(read_data)),
        .q     (img_q)
    );

    page_buffer #(
        .page_t (weight_page_t),
        .DEPTH  (`ACCEL_BUF_DEPTH)
    ) wgt_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .shift (wgt_shift),
        .d     (weight_page_t'(read_data)),
        .q     (wgt_q)
    );

    mac_engine mac_engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_start (mac_start),
        .pixels    (img_q),
        .weights   (wgt_q),
        .res_ack   (res_ack),
        .res_vld   (res_vld),
        .res_data  (res_data)
    );

    // newest image page is the program page right after a fetch
    assign prog_page = mem_page_t'(img_q[0]);

    for (genvar i = 0; i < `ACCEL_INSTR_PER_PAGE; i++) begin : g_instr
        assign instructions[i] = prog_page[i*INSTR_W +: INSTR_W];
    end

    assign write_data = {{(`ACCEL_PAGE_W - ACC_W){res_data[ACC_W-1]}}, res_data};

endmodule

/* tb/mem_model.sv */
`timescale 1ns/1ps
`include "accel_config.svh"

module mem_model #(
    parameter int PAGES = 256,
    parameter int LOG_N = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  accel_pkg::mem_req_t  mem_req,
    input  accel_pkg::mem_page_t write_data,
    output logic                 data_valid,
    output accel_pkg::mem_page_t read_data,
    output logic                 write_done,
    output logic                 overlap_err,
    output logic                 range_err
);
    import accel_pkg::*;

    mem_page_t                mem         [PAGES];
    logic [`ACCEL_ADDR_W-1:0] rd_log      [LOG_N];
    logic [`ACCEL_ADDR_W-1:0] wr_addr_log [LOG_N];
    mem_page_t                wr_data_log [LOG_N];

    int                       rd_cnt  = 0;
    int                       wr_cnt  = 0;
    int                       rd_wait = 0;
    int                       wr_wait = 0;
    logic                     busy;
    logic [`ACCEL_ADDR_W-1:0] rd_addr = '0;
    integer                   seed    = 32'hb367;

    initial begin
        data_valid  = 1'b0;
        read_data   = '0;
        write_done  = 1'b0;
        overlap_err = 1'b0;
        range_err   = 1'b0;
    end

    // requests sampled mid-cycle, answers change on the falling edge
    always @(negedge clk) begin
        data_valid <= 1'b0;
        write_done <= 1'b0;
        if (!rst_n) begin
            rd_wait = 0;
            wr_wait = 0;
        end else begin
            busy = rd_wait > 0 || wr_wait > 0;
            if (rd_wait > 0) begin
                rd_wait = rd_wait - 1;
                if (rd_wait == 0) begin
                    data_valid <= 1'b1;
                    read_data  <= mem[rd_addr];
                end
            end
            if (wr_wait > 0) begin
                wr_wait = wr_wait - 1;
                if (wr_wait == 0) begin
                    write_done <= 1'b1;
                end
            end
            if (mem_req.rd_req || mem_req.wr_req) begin
                if (busy || (mem_req.rd_req && mem_req.wr_req)) begin
                    overlap_err <= 1'b1;
                end
                if (mem_req.addr >= PAGES) begin
                    range_err <= 1'b1;
                end
            end
            if (mem_req.rd_req) begin
                if (rd_cnt < LOG_N) begin
                    rd_log[rd_cnt] = mem_req.addr;
                end
                rd_cnt  = rd_cnt + 1;
                rd_addr = mem_req.addr;
                rd_wait = 1 + ({$random(seed)} % 4);
            end
            if (mem_req.wr_req) begin
                if (wr_cnt < LOG_N) begin
                    wr_addr_log[wr_cnt] = mem_req.addr;
                    wr_data_log[wr_cnt] = write_data;
                end
                wr_cnt = wr_cnt + 1;
                mem[mem_req.addr] = write_data;
                wr_wait = 1 + ({$random(seed)} % 4);
            end
        end
    end

endmodule

/* tb/tb_accel_core.sv */
`timescale 1ns/1ps
`include "accel_config.svh"

module tb_accel_core;
    import accel_pkg::*;

    localparam int MEM_PAGES = 256;
    // whole run needs about 350 cycles even at worst latency
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int WGT_BASE  = 'h10;
    localparam int WGT_BASE2 = 'h18;

    logic      clk;
    logic      rst_n;
    mem_req_t  mem_req;
    logic      data_valid;
    mem_page_t read_data;
    mem_page_t write_data;
    logic      write_done;
    logic      buffer_addr_valid;
    reg_cmd_t  cmd;
    logic      begin_wgt_load;
    logic      begin_proc;
    instr_t    instructions [`ACCEL_INSTR_PER_PAGE];
    logic      instr_vld;
    logic      inc_pc;
    logic      overlap_err;
    logic      range_err;

    mem_page_t ref_mem [MEM_PAGES];
    int        cycle_cnt     = 0;
    int        inc_pc_cnt    = 0;
    int        instr_vld_cnt = 0;
    int        rd_base;
    int        wr_base;
    int        pc_base;

    accel_core accel_core_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_req           (mem_req),
        .data_valid        (data_valid),
        .read_data         (read_data),
        .write_data        (write_data),
        .write_done        (write_done),
        .buffer_addr_valid (buffer_addr_valid),
        .cmd               (cmd),
        .begin_wgt_load    (begin_wgt_load),
        .begin_proc        (begin_proc),
        .instructions      (instructions),
        .instr_vld         (instr_vld),
        .inc_pc            (inc_pc)
    );

    mem_model #(
        .PAGES (MEM_PAGES)
    ) mem_model_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req     (mem_req),
        .write_data  (write_data),
        .data_valid  (data_valid),
        .read_data   (read_data),
        .write_done  (write_done),
        .overlap_err (overlap_err),
        .range_err   (range_err)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: tests not finished after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // pulse counters settle one falling edge late
    always @(negedge clk) begin
        if (inc_pc) begin
            inc_pc_cnt <= inc_pc_cnt + 1;
        end
        if (instr_vld) begin
            instr_vld_cnt <= instr_vld_cnt + 1;
        end
        if (overlap_err) begin
            abort_run("memory got a request while another access was still outstanding");
        end
        if (range_err) begin
            abort_run("memory request addressed a page outside the modeled memory");
        end
    end

    task automatic abort_run(string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run("");
        end
    endtask

    // byte pattern mixed from the whole address
    function automatic mem_page_t fill_page(int a);
        mem_page_t p;
        for (int i = 0; i < `ACCEL_PIX_PER_PAGE; i++) begin
            p[i*8 +: 8] = 8'(a * 37 + i * 91 + (a >> 3) * 13 + 5);
        end
        return p;
    endfunction

    // unsigned pixel times signed weight over one whole image
    function automatic mem_page_t expected_result(int img, int wgt);
        longint sum;
        sum = 0;
        for (int k = 0; k < `ACCEL_IMG_PAGES; k++) begin
            for (int i = 0; i < `ACCEL_PIX_PER_PAGE; i++) begin
                sum += longint'(ref_mem[img + k][i*8 +: 8])
                     * longint'($signed(ref_mem[wgt + k][i*8 +: 8]));
            end
        end
        return mem_page_t'(sum);
    endfunction

    task automatic mark_logs();
        rd_base = mem_model_i.rd_cnt;
        wr_base = mem_model_i.wr_cnt;
        pc_base = inc_pc_cnt;
    endtask

    task automatic write_reg(reg_sel_t sel, int data);
        cmd.wr_en = 1'b1;
        cmd.sel   = sel;
        cmd.data  = `ACCEL_ADDR_W'(data);
        @(negedge clk);
        cmd = '0;
    endtask

    task automatic pulse_begin(logic wgt, int addr);
        cmd.data       = `ACCEL_ADDR_W'(addr);
        begin_wgt_load = wgt;
        begin_proc     = !wgt;
        @(negedge clk);
        cmd            = '0;
        begin_wgt_load = 1'b0;
        begin_proc     = 1'b0;
    endtask

    // a few idle cycles after inc_pc catch stray activity
    task automatic wait_done();
        do @(negedge clk); while (!inc_pc);
        repeat (6) @(negedge clk);
    endtask

    task automatic check_reads(string what, int first, int n);
        check_value({what, " read count"}, mem_model_i.rd_cnt - rd_base, n);
        for (int k = 0; k < n; k++) begin
            check_value($sformatf("%s read %0d address", what, k),
                        mem_model_i.rd_log[rd_base + k], first + k);
        end
    endtask

    task automatic check_write(int k, int addr, mem_page_t data);
        check_value($sformatf("write %0d address", k), mem_model_i.wr_addr_log[wr_base + k], addr);
        check_value($sformatf("write %0d data", k), mem_model_i.wr_data_log[wr_base + k], data);
    endtask

    task automatic check_counts(string what, int n_writes);
        check_value({what, " write count"}, mem_model_i.wr_cnt - wr_base, n_writes);
        check_value({what, " inc_pc pulses"}, inc_pc_cnt - pc_base, 1);
    endtask

    task automatic process_images(string what, int img, int cnt, int res);
        mark_logs();
        write_reg(REG_IMG_ADDR, img);
        write_reg(REG_IMG_CNT, cnt);
        write_reg(REG_RES_ADDR, res);
        pulse_begin(1'b0, img);
        wait_done();
        check_reads(what, img, cnt * `ACCEL_IMG_PAGES);
        check_counts(what, cnt);
    endtask

    task automatic test_program_fetch();
        mark_logs();
        buffer_addr_valid = 1'b1;
        do @(negedge clk); while (!instr_vld);
        for (int i = 0; i < `ACCEL_INSTR_PER_PAGE; i++) begin
            check_value($sformatf("instructions[%0d]", i), instructions[i], ref_mem[0][i*32 +: 32]);
        end
        repeat (4) @(negedge clk);
        check_value("instr_vld pulses", instr_vld_cnt, 1);
        check_reads("program fetch", 0, 1);
    endtask

    task automatic test_register_writes();
        process_images("register writes", 'h20, 1, 'hc0);
        // weight buffer still cleared from reset
        check_write(0, 'hc0, '0);
    endtask

    task automatic test_weight_load();
        mark_logs();
        pulse_begin(1'b1, WGT_BASE);
        wait_done();
        check_reads("weight load", WGT_BASE, `ACCEL_IMG_PAGES);
        check_counts("weight load", 0);
    endtask

    task automatic test_single_image();
        process_images("single image", 'h40, 1, 'hc8);
        check_write(0, 'hc8, expected_result('h40, WGT_BASE));
    endtask

    task automatic test_three_images();
        process_images("three images", 'h60, 3, 'hd0);
        for (int n = 0; n < 3; n++) begin
            check_write(n, 'hd0 + n, expected_result('h60 + n * `ACCEL_IMG_PAGES, WGT_BASE));
        end
    endtask

    task automatic test_ignored_command();
        mark_logs();
        // a pending image would show up as extra reads if begin_proc slipped through
        write_reg(REG_IMG_CNT, 1);
        $assertoff(0, accel_core_inst.ctrl_unit_i);
        pulse_begin(1'b1, WGT_BASE2);
        repeat (2) @(negedge clk);
        pulse_begin(1'b0, 'h20);
        wait_done();
        $asserton(0, accel_core_inst.ctrl_unit_i);
        check_reads("ignored begin_proc", WGT_BASE2, `ACCEL_IMG_PAGES);
        check_counts("ignored begin_proc", 0);
    endtask

    initial begin
        rst_n             = 1'b0;
        buffer_addr_valid = 1'b0;
        cmd               = '0;
        begin_wgt_load    = 1'b0;
        begin_proc        = 1'b0;
        for (int a = 0; a < MEM_PAGES; a++) begin
            ref_mem[a] = fill_page(a);
        end
        // program page, two instruction words
        ref_mem[0] = 64'h0c80_0013_2a40_0007;
        for (int a = 0; a < MEM_PAGES; a++) begin
            mem_model_i.mem[a] = ref_mem[a];
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_program_fetch();
        test_register_writes();
        test_weight_load();
        test_single_image();
        test_three_images();
        test_ignored_command();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/accel_pkg.sv
hdl/page_buffer.sv
hdl/mac_engine.sv
hdl/ctrl_unit.sv
hdl/accel_core.sv
tb/mem_model.sv
tb/tb_accel_core.sv
